//--- source/mipsPkg.sv
package mipsPkg;

  localparam int dataWidth = 32;
  localparam int regAddrWidth = 5;
  localparam logic [31:0] resetVector = 32'hBFC0_0000;

  // ALU operand B select
  localparam logic [1:0] srcBRt = 2'b00;
  localparam logic [1:0] srcBFour = 2'b01;
  localparam logic [1:0] srcBImm = 2'b10;
  localparam logic [1:0] srcBShift = 2'b11;

  // Source of the pending jump target
  localparam logic [1:0] tgtBranch = 2'd0;
  localparam logic [1:0] tgtJump = 2'd1;
  localparam logic [1:0] tgtReg = 2'd2;

  typedef enum logic [5:0] {
    opRType = 6'b000000,
    opJ     = 6'b000010,
    opBeq   = 6'b000100,
    opBne   = 6'b000101,
    opAddiu = 6'b001001,
    opSlti  = 6'b001010,
    opSltiu = 6'b001011,
    opAndi  = 6'b001100,
    opOri   = 6'b001101,
    opLw    = 6'b100011,
    opSw    = 6'b101011
  } opcodeT;

  typedef enum logic [5:0] {
    fnJr   = 6'b001000,
    fnAddu = 6'b100001,
    fnAnd  = 6'b100100,
    fnOr   = 6'b100101
  } functT;

  typedef enum logic [2:0] {
    stFetch  = 3'b000,
    stDecode = 3'b001,
    stExec1  = 3'b010,
    stExec2  = 3'b011,
    stExec3  = 3'b100,
    stHalted = 3'b101,
    stStall  = 3'b110
  } cpuStateT;

  typedef enum logic [2:0] {
    aluAdd,
    aluAnd,
    aluOr,
    aluSlt,
    aluSltu,
    aluEq,
    aluPassA
  } aluOpT;

  typedef struct packed {
    opcodeT opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    functT funct;
  } rTypeT;

  typedef struct packed {
    opcodeT opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [15:0] imm;
  } iTypeT;

  typedef struct packed {
    opcodeT opcode;
    logic [25:0] target;
  } jTypeT;

  typedef union packed {
    rTypeT rFields;
    iTypeT iFields;
    jTypeT jFields;
  } instrWordT;

  typedef struct packed {
    logic [dataWidth-1:0] address;
    logic read;
    logic write;
    logic [dataWidth-1:0] writeData;
  } memReqT;

  typedef struct packed {
    logic iOrD;         // Bus address from ALU output
    logic irWrite;
    logic pcWrite;
    logic regWrite;
    logic regDst;       // Write rd instead of rt
    logic memToReg;
    logic aluSrcA;      // rs when set, else PC
    logic [1:0] aluSrcB;
    aluOpT aluOp;
    logic zeroExtend;
    logic aluOutWrite;
    logic setTarget;
    logic [1:0] targetSel;
    logic branchTaken;
    logic memRead;
    logic memWrite;
  } ctrlWordT;

  typedef struct packed {
    logic aluZero;
    logic pcIsZero;
    instrWordT instr;
  } dpStatusT;

endpackage

//--- source/alu.sv
`timescale 1ns/1ps

module alu import mipsPkg::*; (
  input aluOpT aluOp,
  input logic [dataWidth-1:0] srcA,
  input logic [dataWidth-1:0] srcB,
  output logic [dataWidth-1:0] result,
  output logic zero
);

  logic lessSigned;
  logic lessUnsigned;

  assign lessSigned = $signed(srcA) < $signed(srcB);
  assign lessUnsigned = srcA < srcB;

  always_comb begin
    case (aluOp)
      aluAdd: result = srcA + srcB;
      aluAnd: result = srcA & srcB;
      aluOr: result = srcA | srcB;
      aluSlt: result = {{(dataWidth-1){1'b0}}, lessSigned};
      aluSltu: result = {{(dataWidth-1){1'b0}}, lessUnsigned};
      aluEq: result = {{(dataWidth-1){1'b0}}, srcA == srcB};
      aluPassA: result = srcA;
      default: result = '0;
    endcase
  end

  // Branch compare reads this
  assign zero = (result == '0);

endmodule

//--- source/registerFile.sv
`timescale 1ns/1ps

module registerFile import mipsPkg::*; (
  input logic clk,
  input logic arstN,
  input logic writeEnable,
  input logic [regAddrWidth-1:0] readAddrA,
  input logic [regAddrWidth-1:0] readAddrB,
  input logic [regAddrWidth-1:0] writeAddr,
  input logic [dataWidth-1:0] writeData,
  output logic [dataWidth-1:0] readDataA,
  output logic [dataWidth-1:0] readDataB,
  output logic [dataWidth-1:0] regV0
);

  logic [dataWidth-1:0] regs [1:31];   // No storage for $zero

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable && (writeAddr != '0)) begin
      regs[writeAddr] <= writeData;
    end
  end

  assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
  assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];
  assign regV0 = regs[2];

endmodule

//--- source/pcUnit.sv
`timescale 1ns/1ps

module pcUnit import mipsPkg::*; (
  input logic clk,
  input logic arstN,
  input logic pcWrite,
  input logic setTarget,
  input logic branchTaken,
  input logic [1:0] targetSel,
  input logic [dataWidth-1:0] branchOffset,
  input logic [dataWidth-1:0] jumpTarget,
  input logic [dataWidth-1:0] regTarget,
  output logic [dataWidth-1:0] pc,
  output logic pcIsZero
);

  logic [dataWidth-1:0] targetNext;
  logic [dataWidth-1:0] pendingTarget;
  logic pending;

  // PC already points at the delay slot here
  always_comb begin
    case (targetSel)
      tgtBranch: targetNext = pc + branchOffset;
      tgtJump: targetNext = jumpTarget;
      default: targetNext = regTarget;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= resetVector;
      pending <= 1'b0;
    end else if (setTarget) begin
      pending <= branchTaken;   // Untaken branch leaves nothing pending
    end else if (pcWrite) begin
      pc <= pending ? pendingTarget : pc + 32'd4;
      pending <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (setTarget) pendingTarget <= targetNext;
  end

  assign pcIsZero = (pc == '0);

endmodule

//--- source/datapath.sv
`timescale 1ns/1ps

module datapath import mipsPkg::*; (
  input logic clk,
  input logic arstN,
  input ctrlWordT ctrl,
  input logic [dataWidth-1:0] readData,
  output dpStatusT status,
  output memReqT memReq,
  output logic [dataWidth-1:0] regV0
);

  instrWordT ir;
  logic [dataWidth-1:0] mdr;
  logic [dataWidth-1:0] aluOut;
  logic [dataWidth-1:0] pc;
  logic [dataWidth-1:0] rsData;
  logic [dataWidth-1:0] rtData;
  logic [dataWidth-1:0] immExt;
  logic [dataWidth-1:0] immShift;
  logic [dataWidth-1:0] jumpTarget;
  logic [dataWidth-1:0] srcA;
  logic [dataWidth-1:0] srcB;
  logic [dataWidth-1:0] aluResult;
  logic [dataWidth-1:0] wbData;
  logic [regAddrWidth-1:0] wbAddr;
  logic aluZero;
  logic pcIsZero;

  always_ff @(posedge clk) begin
    if (ctrl.irWrite) ir <= readData;
    if (ctrl.memRead && ctrl.iOrD) mdr <= readData;   // Last value is the completed read
    if (ctrl.aluOutWrite) aluOut <= aluResult;
  end

  assign immExt = ctrl.zeroExtend ? {16'b0, ir.iFields.imm}
                                  : {{16{ir.iFields.imm[15]}}, ir.iFields.imm};
  assign immShift = {{14{ir.iFields.imm[15]}}, ir.iFields.imm, 2'b00};
  assign jumpTarget = {pc[31:28], ir.jFields.target, 2'b00};

  assign srcA = ctrl.aluSrcA ? rsData : pc;
  always_comb begin
    case (ctrl.aluSrcB)
      srcBRt: srcB = rtData;
      srcBFour: srcB = 32'd4;
      srcBImm: srcB = immExt;
      default: srcB = immShift;
    endcase
  end

  assign wbAddr = ctrl.regDst ? ir.rFields.rd : ir.rFields.rt;
  assign wbData = ctrl.memToReg ? mdr : aluOut;

  assign memReq.address = ctrl.iOrD ? aluOut : pc;
  assign memReq.read = ctrl.memRead;
  assign memReq.write = ctrl.memWrite;
  assign memReq.writeData = rtData;

  assign status.aluZero = aluZero;
  assign status.pcIsZero = pcIsZero;
  assign status.instr = ir;

  registerFile uRegs (
    .clk(clk),
    .arstN(arstN),
    .writeEnable(ctrl.regWrite),
    .readAddrA(ir.rFields.rs),
    .readAddrB(ir.rFields.rt),
    .writeAddr(wbAddr),
    .writeData(wbData),
    .readDataA(rsData),
    .readDataB(rtData),
    .regV0(regV0)
  );

  alu uAlu (
    .aluOp(ctrl.aluOp),
    .srcA(srcA),
    .srcB(srcB),
    .result(aluResult),
    .zero(aluZero)
  );

  pcUnit uPc (
    .clk(clk),
    .arstN(arstN),
    .pcWrite(ctrl.pcWrite),
    .setTarget(ctrl.setTarget),
    .branchTaken(ctrl.branchTaken),
    .targetSel(ctrl.targetSel),
    .branchOffset(immShift),
    .jumpTarget(jumpTarget),
    .regTarget(aluResult),   // JR passes rs through the ALU
    .pc(pc),
    .pcIsZero(pcIsZero)
  );

endmodule

//--- source/controlFsm.sv
`timescale 1ns/1ps

module controlFsm import mipsPkg::*; (
  input logic clk,
  input logic arstN,
  input logic waitRequest,
  input dpStatusT status,
  output ctrlWordT ctrl,
  output logic active
);

  cpuStateT state;
  cpuStateT stateNext;
  cpuStateT doneState;
  opcodeT opcode;
  functT funct;
  logic isJr;
  logic isMem;
  logic writesReg;

  assign opcode = status.instr.rFields.opcode;
  assign funct = status.instr.rFields.funct;
  assign isJr = (opcode == opRType) && (funct == fnJr);
  assign isMem = (opcode == opLw) || (opcode == opSw);

  // Jump to address 0 ends the program once its delay slot is done
  assign doneState = status.pcIsZero ? stHalted : stFetch;

  always_comb begin
    case (opcode)
      opRType: writesReg = (funct == fnAddu) || (funct == fnAnd) || (funct == fnOr);
      opAddiu, opAndi, opOri, opSlti, opSltiu: writesReg = 1'b1;
      default: writesReg = 1'b0;
    endcase
  end

  always_comb begin
    stateNext = state;
    if (active) begin
      case (state)
        stFetch, stStall: stateNext = waitRequest ? stStall : stDecode;
        stDecode: stateNext = stExec1;
        stExec1: stateNext = (writesReg || isMem) ? stExec2 : doneState;
        stExec2: begin
          if (isMem && waitRequest) begin
            stateNext = stExec2;    // Data transfer still pending
          end else if (opcode == opLw) begin
            stateNext = stExec3;
          end else begin
            stateNext = doneState;
          end
        end
        stExec3: stateNext = doneState;
        default: stateNext = stHalted;
      endcase
    end
  end

  // active rises one clock after reset and falls on entry to halted
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= stFetch;
      active <= 1'b0;
    end else begin
      state <= stateNext;
      active <= (stateNext != stHalted);
    end
  end

  always_comb begin
    ctrl = '0;
    ctrl.aluOp = aluAdd;
    if (active) begin
      case (state)
        stFetch, stStall: begin
          ctrl.memRead = 1'b1;
          ctrl.aluSrcB = srcBFour;
          ctrl.irWrite = !waitRequest;
          ctrl.pcWrite = !waitRequest;   // PC+4 or the pending target
        end
        stExec1: begin
          ctrl.aluSrcA = 1'b1;
          ctrl.aluSrcB = srcBImm;
          ctrl.aluOutWrite = writesReg || isMem;
          case (opcode)
            opRType: begin
              ctrl.aluSrcB = srcBRt;
              case (funct)
                fnAnd: ctrl.aluOp = aluAnd;
                fnOr: ctrl.aluOp = aluOr;
                fnJr: ctrl.aluOp = aluPassA;  // rs straight to the PC unit
                default: ctrl.aluOp = aluAdd;
              endcase
              ctrl.setTarget = isJr;
              ctrl.targetSel = tgtReg;
              ctrl.branchTaken = isJr;
            end
            opAndi: begin
              ctrl.aluOp = aluAnd;
              ctrl.zeroExtend = 1'b1;
            end
            opOri: begin
              ctrl.aluOp = aluOr;
              ctrl.zeroExtend = 1'b1;
            end
            opSlti: ctrl.aluOp = aluSlt;
            opSltiu: ctrl.aluOp = aluSltu;   // Sign-extended, compared unsigned
            opBeq, opBne: begin
              ctrl.aluSrcB = srcBRt;
              ctrl.aluOp = aluEq;
              ctrl.setTarget = 1'b1;
              ctrl.targetSel = tgtBranch;
              // Equal operands give a nonzero result
              ctrl.branchTaken = (opcode == opBeq) ^ status.aluZero;
            end
            opJ: begin
              ctrl.setTarget = 1'b1;
              ctrl.targetSel = tgtJump;
              ctrl.branchTaken = 1'b1;
            end
            default: ctrl.aluOp = aluAdd;   // Address calc and ADDIU
          endcase
        end
        stExec2: begin
          ctrl.iOrD = isMem;
          ctrl.memRead = (opcode == opLw);
          ctrl.memWrite = (opcode == opSw);
          ctrl.regWrite = writesReg;
          ctrl.regDst = (opcode == opRType);
        end
        stExec3: begin
          ctrl.regWrite = 1'b1;
          ctrl.memToReg = 1'b1;   // Load result into rt
        end
        default: ctrl.aluOp = aluAdd;
      endcase
    end
  end

endmodule

//--- source/mipsCpu.sv
`timescale 1ns/1ps

module mipsCpu import mipsPkg::*; (
  input logic clk,
  input logic arstN,
  output memReqT memReq,
  input logic [dataWidth-1:0] readData,
  input logic waitRequest,
  output logic active,
  output logic [dataWidth-1:0] regV0
);

  ctrlWordT ctrl;
  dpStatusT status;

  // Sequencing and decode
  controlFsm uControl (
    .clk(clk),
    .arstN(arstN),
    .waitRequest(waitRequest),
    .status(status),
    .ctrl(ctrl),
    .active(active)
  );

  // Registers, ALU and PC
  datapath uDatapath (
    .clk(clk),
    .arstN(arstN),
    .ctrl(ctrl),
    .readData(readData),
    .status(status),
    .memReq(memReq),
    .regV0(regV0)
  );

endmodule

//--- tests/clockGen.sv
`timescale 1ns/1ps

module clockGen (
  output logic clk
);

  localparam int halfPeriod = 10;   // 20 ns period

  initial begin
    clk = 1'b0;
    forever #(halfPeriod) clk = ~clk;
  end

endmodule

//--- tests/mipsCpuTb.sv
`timescale 1ns/1ps

module mipsCpuTb import mipsPkg::*; ();

  localparam int memWords = 256;
  localparam int progWords = 36;
  localparam int maxInstrCycles = 5;
  localparam int watchdogNs = 40 * progWords * maxInstrCycles * 20;
  localparam logic [31:0] bootAddr = 32'hBFC0_0000;   // First fetch and base of the image
  localparam logic [7:0] expBase = 8'hC0;   // v0, write count, then address/data pairs

  logic clk;
  logic arstN;
  memReqT memReq;
  logic [31:0] readData;
  logic waitRequest;
  logic active;
  logic [31:0] regV0;

  logic [31:0] mem [0:memWords-1];
  logic [31:0] lcgState;
  logic [1:0] waitLeft;
  logic busy;
  logic released;
  logic seenFirst;
  logic lastStalled;
  memReqT lastReq;
  int resetEdges;
  int writeCount;

  clockGen uClock (.clk(clk));

  mipsCpu DUT (
    .clk(clk),
    .arstN(arstN),
    .memReq(memReq),
    .readData(readData),
    .waitRequest(waitRequest),
    .active(active),
    .regV0(regV0)
  );

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Byte address to word slot relative to the image base
  function automatic logic [7:0] wordIndex(input logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - bootAddr;
    return offset[9:2];
  endfunction

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic recordWrite(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] expAddr;
    logic [31:0] expData;
    assert (writeCount < int'(mem[expBase + 8'd1])) else
      failRun($sformatf("[ERROR] %0t ns: extra write of 0x%08h to 0x%08h", $time, data, addr));
    expAddr = mem[8'(expBase + 2 + 2 * writeCount)];
    expData = mem[8'(expBase + 3 + 2 * writeCount)];
    assert (addr == expAddr && data == expData) else
      failRun($sformatf("[ERROR] %0t ns: write %0d is 0x%08h to 0x%08h, expected 0x%08h to 0x%08h",
                        $time, writeCount, data, addr, expData, expAddr));
    mem[wordIndex(addr)] = data;
    writeCount++;
  endtask

  // Memory model with at least one wait cycle per request
  always @(posedge clk) begin
    logic reqActive;
    reqActive = memReq.read || memReq.write;
    if (!arstN || !released) begin
      if (resetEdges > 0) begin
        assert (!memReq.read && !memReq.write && !active) else
          failRun($sformatf("[ERROR] %0t ns: bus or active not idle around reset", $time));
      end
      resetEdges++;
      released = arstN;
    end else begin
      if (lastStalled) begin
        assert (memReq == lastReq) else
          failRun($sformatf("[ERROR] %0t ns: request changed under waitRequest", $time));
      end
      assert (!(memReq.read && memReq.write)) else
        failRun($sformatf("[ERROR] %0t ns: read and write high together", $time));
      if (reqActive && !seenFirst) begin
        assert (memReq.read && memReq.address == bootAddr) else
          failRun($sformatf("[ERROR] %0t ns: first request at 0x%08h", $time, memReq.address));
        seenFirst = 1'b1;
      end
      if (reqActive && !waitRequest) begin
        if (memReq.write) recordWrite(memReq.address, memReq.writeData);
        busy = 1'b0;
        waitRequest <= 1'b1;
      end else if (reqActive) begin
        if (!busy) begin
          lcgState = lcgNext(lcgState);
          waitLeft = lcgState[17:16];   // Extra wait cycles
          busy = 1'b1;
        end
        if (waitLeft == 2'd0) begin
          readData <= mem[wordIndex(memReq.address)];
          waitRequest <= 1'b0;
        end else begin
          waitLeft = waitLeft - 2'd1;
        end
      end
      lastReq = memReq;
      lastStalled = reqActive && waitRequest;
    end
  end

  initial begin
    arstN = 1'b0;
    waitRequest = 1'b1;
    readData = '0;
    lcgState = 32'd62894;
    waitLeft = 2'd0;
    busy = 1'b0;
    released = 1'b0;
    seenFirst = 1'b0;
    lastStalled = 1'b0;
    lastReq = '0;
    resetEdges = 0;
    writeCount = 0;
    for (int i = 0; i < memWords; i++) begin
      mem[8'(i)] = (bootAddr + 32'(i) * 4) ^ 32'h5A5A_5A5A;
    end
    $readmemh("tests/cpuStimulus.mem", mem);
    repeat (2) @(posedge clk);
    arstN <= 1'b1;
    @(posedge clk);
    while (!(seenFirst && !active)) @(posedge clk);
    repeat (20) begin   // Halted CPU stays off the bus
      @(posedge clk);
      assert (!memReq.read && !memReq.write && !active) else
        failRun("The CPU used the bus or became active again after the halt");
    end
    assert (writeCount == int'(mem[expBase + 8'd1])) else
      failRun($sformatf("Only %0d of %0d expected writes happened before the halt",
                        writeCount, int'(mem[expBase + 8'd1])));
    assert (regV0 == mem[expBase]) else
      failRun($sformatf("[ERROR] %0t ns: v0 is 0x%08h, expected 0x%08h",
                        $time, regV0, mem[expBase]));
    $display("Done: no errors");
    $finish;
  end

  initial begin
    #(watchdogNs);
    failRun($sformatf("Timeout: the CPU did not halt within %0d ns", watchdogNs));
  end

endmodule

//--- tests/cpuStimulus.mem
// Word image of CPU memory, slot = (address - BFC00000) / 4, 256 slots
// @00 program, @82 and @86 data, @C0 expected v0 and write count, then address/data pairs
@00
24080055 2409FFFD 01095021 AC0A0200  // addiu, addiu, addu, sw
312B0F0F 350CA000 016C6824 016C7025  // andi, ori, and, or
292F0001 2D18FFFF AC0E0204 8C100208  // slti, sltiu, sw, lw
11090003 AC10020C 15090003 AC0D0210  // beq untaken + slot, bne taken + slot
AC0002FC AC0002FC 11EF0003 01CF1021  // skipped stores, beq taken + slot addu v0
AC0002FC AC0002FC 0BF0001A AC020214  // skipped stores, j + slot store
AC0002FC AC0002FC 8C110218 02200008  // skipped stores, lw jump address, jr
24420100 AC0002FC AC02021C 15EF0002  // slot addiu v0, skipped, jr target store, bne untaken
00581021 00000008 AC020220 AC0002FC  // slot addu v0, jr $0, slot store, never reached
@82
12345678
@86
BFC00078
@C0
0000B05F 00000007  // expected v0, number of writes
00000200 00000052
00000204 0000AF5D
0000020C 12345678
00000210 00000005
00000214 0000AF5E
0000021C 0000B05E
00000220 0000B05F

//--- mipsCpu.f
source/mipsPkg.sv
source/alu.sv
source/registerFile.sv
source/pcUnit.sv
source/datapath.sv
source/controlFsm.sv
source/mipsCpu.sv
tests/clockGen.sv
tests/mipsCpuTb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST ?= mipsCpu.f
TB_TOP ?= mipsCpuTb
RTL_TOP ?= mipsCpu
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || { echo "Simulation did not complete"; exit 1; }

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
